// ==== rtl/mdu_cfg.svh ====
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// integer register width and the word-op width
`define MDU_XLEN 64
`define MDU_WLEN 32

// one restoring iteration per quotient bit
`define MDU_DIV_ITER_D 64
`define MDU_DIV_ITER_W 32

// must hold MDU_DIV_ITER_D
`define MDU_CNT_W 7

`endif

// ==== rtl/mdu_pkg.sv ====
`include "mdu_cfg.svh"

package mdu_pkg;

	typedef logic [`MDU_XLEN-1:0] xlen_t;
	typedef logic [`MDU_WLEN-1:0] wlen_t;

	// encoded as funct3 of the M extension
	typedef enum logic [2:0] {
		OP_MUL    = 3'b000,
		OP_MULH   = 3'b001,
		OP_MULHSU = 3'b010,
		OP_MULHU  = 3'b011,
		OP_DIV    = 3'b100,
		OP_DIVU   = 3'b101,
		OP_REM    = 3'b110,
		OP_REMU   = 3'b111
	} mdu_op_e;

	// top funct3 bit splits divide/remainder from multiply
	function automatic logic is_div(mdu_op_e op);
		return op[2];
	endfunction

endpackage

// ==== rtl/mdu_ctrl.sv ====
`timescale 1ns/10ps

module mdu_ctrl (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             valid_i,
	input  mdu_pkg::mdu_op_e op_i,
	input  logic             last_i,
	output logic             ready_o,
	output logic             mul_load_o,
	output logic             div_load_o,
	output logic             cnt_start_o,
	output logic             div_step_o,
	output logic             div_fix_o,
	output logic             res_sel_o,
	output logic             done_o
);
	import mdu_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_MUL,
		S_DIV,
		S_FIX
	} state_e;

	state_e state_q;
	state_e state_d;
	logic   accept;
	logic   first_q;
	logic   done_q;
	logic   res_sel_q;

	assign accept = valid_i && (state_q == S_IDLE);

	// load strobes fire on the accepting edge itself
	assign mul_load_o  = accept && !is_div(op_i);
	assign div_load_o  = accept && is_div(op_i);
	assign cnt_start_o = div_load_o;

	// first cycle in DIV is the load cycle, no shift yet
	assign div_step_o = (state_q == S_DIV) && !first_q;
	assign div_fix_o  = (state_q == S_FIX);
	assign ready_o    = (state_q == S_IDLE);
	assign done_o     = done_q;
	assign res_sel_o  = res_sel_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (accept) begin
					state_d = is_div(op_i) ? S_DIV : S_MUL;
				end
			end
			S_MUL: state_d = S_IDLE;
			S_DIV: begin
				// counter alone marks the final iteration
				if (div_step_o && last_i) begin
					state_d = S_FIX;
				end
			end
			S_FIX: state_d = S_IDLE;
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q   <= S_IDLE;
			first_q   <= 1'b0;
			done_q    <= 1'b0;
			res_sel_q <= 1'b0;
		end else begin
			state_q <= state_d;
			first_q <= div_load_o;
			done_q  <= (state_q == S_MUL) || (state_q == S_FIX);
			// switch the output mux together with done so result_o holds
			if ((state_q == S_MUL) || (state_q == S_FIX)) begin
				res_sel_q <= (state_q == S_FIX);
			end
		end
	end

endmodule

// ==== rtl/div_step_counter.sv ====
`timescale 1ns/10ps

`include "mdu_cfg.svh"

module div_step_counter (
	input  logic clk,
	input  logic rst_n_i,
	input  logic cnt_start_i,
	input  logic step_i,
	input  logic word_i,
	output logic last_o
);

	logic [`MDU_CNT_W-1:0] cnt_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (cnt_start_i) begin
			// word ops need only half the quotient bits
			if (word_i) begin
				cnt_q <= `MDU_CNT_W'(`MDU_DIV_ITER_W);
			end else begin
				cnt_q <= `MDU_CNT_W'(`MDU_DIV_ITER_D);
			end
		end else if (step_i && (cnt_q != '0)) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// one iteration left, so this step is the final one
	assign last_o = (cnt_q == `MDU_CNT_W'(1));

endmodule

// ==== rtl/div_datapath.sv ====
`timescale 1ns/10ps

`include "mdu_cfg.svh"

module div_datapath (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             load_i,
	input  logic             step_i,
	input  logic             fix_i,
	input  mdu_pkg::mdu_op_e op_i,
	input  logic             word_i,
	input  mdu_pkg::xlen_t   rs1_i,
	input  mdu_pkg::xlen_t   rs2_i,
	output mdu_pkg::xlen_t   result_o
);
	import mdu_pkg::*;

	localparam int EXT = `MDU_XLEN - `MDU_WLEN;

	logic                 signed_op;
	xlen_t                dvd_ext;
	xlen_t                dvs_ext;
	logic                 dvd_neg;
	logic                 dvs_neg;
	xlen_t                dvd_abs;
	xlen_t                dvs_abs;

	xlen_t                dvs_q;
	xlen_t                rem_q;
	xlen_t                quot_q;
	logic                 dvd_neg_q;
	logic                 dvs_neg_q;
	logic                 zero_q;
	logic                 word_q;
	logic                 rem_sel_q;

	logic [`MDU_XLEN+1:0] trial;
	xlen_t                quot_fix;
	xlen_t                rem_fix;
	xlen_t                res_sel;
	wlen_t                res_w;
	xlen_t                result_q;

	assign signed_op = (op_i == OP_DIV) || (op_i == OP_REM);

	// word forms see only the low half of each operand
	always_comb begin
		if (word_i) begin
			dvd_ext = {{EXT{signed_op & rs1_i[`MDU_WLEN-1]}}, rs1_i[`MDU_WLEN-1:0]};
			dvs_ext = {{EXT{signed_op & rs2_i[`MDU_WLEN-1]}}, rs2_i[`MDU_WLEN-1:0]};
		end else begin
			dvd_ext = rs1_i;
			dvs_ext = rs2_i;
		end
	end

	assign dvd_neg = signed_op & dvd_ext[`MDU_XLEN-1];
	assign dvs_neg = signed_op & dvs_ext[`MDU_XLEN-1];
	// most negative value maps onto itself, which is right as unsigned
	assign dvd_abs = dvd_neg ? -dvd_ext : dvd_ext;
	assign dvs_abs = dvs_neg ? -dvs_ext : dvs_ext;

	// shifted partial remainder minus divisor, top bit is the borrow
	assign trial = {1'b0, rem_q, quot_q[`MDU_XLEN-1]} - {2'b00, dvs_q};

	always_ff @(posedge clk) begin
		if (load_i) begin
			dvs_q     <= dvs_abs;
			rem_q     <= '0;
			// left-align the word dividend so 32 shifts consume it
			quot_q    <= word_i ? {dvd_abs[`MDU_WLEN-1:0], {EXT{1'b0}}} : dvd_abs;
			dvd_neg_q <= dvd_neg;
			dvs_neg_q <= dvs_neg;
			zero_q    <= (dvs_ext == '0);
			word_q    <= word_i;
			rem_sel_q <= (op_i == OP_REM) || (op_i == OP_REMU);
		end else if (step_i) begin
			if (!trial[`MDU_XLEN+1]) begin
				rem_q  <= trial[`MDU_XLEN-1:0];
				quot_q <= {quot_q[`MDU_XLEN-2:0], 1'b1};
			end else begin
				rem_q  <= {rem_q[`MDU_XLEN-2:0], quot_q[`MDU_XLEN-1]};
				quot_q <= {quot_q[`MDU_XLEN-2:0], 1'b0};
			end
		end
	end

	// divide by zero already leaves all ones, so keep it unsigned
	assign quot_fix = ((dvd_neg_q ^ dvs_neg_q) && !zero_q) ? -quot_q : quot_q;
	assign rem_fix  = dvd_neg_q ? -rem_q : rem_q;
	assign res_sel  = rem_sel_q ? rem_fix : quot_fix;
	assign res_w    = res_sel[`MDU_WLEN-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			result_q <= '0;
		end else if (fix_i) begin
			result_q <= word_q ? {{EXT{res_w[`MDU_WLEN-1]}}, res_w} : res_sel;
		end
	end

	assign result_o = result_q;

endmodule

// ==== rtl/mul_datapath.sv ====
`timescale 1ns/10ps

`include "mdu_cfg.svh"

module mul_datapath (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             load_i,
	input  mdu_pkg::mdu_op_e op_i,
	input  logic             word_i,
	input  mdu_pkg::xlen_t   rs1_i,
	input  mdu_pkg::xlen_t   rs2_i,
	output mdu_pkg::xlen_t   result_o
);
	import mdu_pkg::*;

	localparam int EXT = `MDU_XLEN - `MDU_WLEN;

	logic                          a_sgn;
	logic                          b_sgn;
	logic signed [`MDU_XLEN:0]     a_q;
	logic signed [`MDU_XLEN:0]     b_q;
	logic                          hi_q;
	logic                          word_q;
	logic                          load_q;
	logic signed [2*`MDU_XLEN+1:0] prod;
	logic [2*`MDU_XLEN-1:0]        prod_q;
	logic                          hi_sel_q;
	logic                          word_sel_q;
	wlen_t                         lo_w;

	// MUL takes the low half, any extension gives the same bits there
	assign a_sgn = (op_i == OP_MULH) || (op_i == OP_MULHSU);
	assign b_sgn = (op_i == OP_MULH);

	always_ff @(posedge clk) begin
		if (load_i) begin
			a_q    <= {a_sgn & rs1_i[`MDU_XLEN-1], rs1_i};
			b_q    <= {b_sgn & rs2_i[`MDU_XLEN-1], rs2_i};
			hi_q   <= (op_i != OP_MUL);
			word_q <= word_i;
		end
	end

	// 65x65 signed covers every signedness mix
	assign prod = a_q * b_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			load_q     <= 1'b0;
			prod_q     <= '0;
			hi_sel_q   <= 1'b0;
			word_sel_q <= 1'b0;
		end else begin
			load_q <= load_i;
			if (load_q) begin
				prod_q     <= prod[2*`MDU_XLEN-1:0];
				hi_sel_q   <= hi_q;
				word_sel_q <= word_q;
			end
		end
	end

	assign lo_w = prod_q[`MDU_WLEN-1:0];

	always_comb begin
		if (word_sel_q) begin
			result_o = {{EXT{lo_w[`MDU_WLEN-1]}}, lo_w};
		end else if (hi_sel_q) begin
			result_o = prod_q[2*`MDU_XLEN-1:`MDU_XLEN];
		end else begin
			result_o = prod_q[`MDU_XLEN-1:0];
		end
	end

endmodule

// ==== rtl/mdu_top.sv ====
`timescale 1ns/10ps

module mdu_top (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             valid_i,
	input  mdu_pkg::mdu_op_e op_i,
	input  logic             word_i,
	input  mdu_pkg::xlen_t   rs1_i,
	input  mdu_pkg::xlen_t   rs2_i,
	output logic             ready_o,
	output logic             done_o,
	output mdu_pkg::xlen_t   result_o
);
	import mdu_pkg::*;

	logic  mul_load;
	logic  div_load;
	logic  cnt_start;
	logic  div_step;
	logic  div_fix;
	logic  res_sel;
	logic  last;
	xlen_t mul_res;
	xlen_t div_res;

	mdu_ctrl u_ctrl (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.valid_i     (valid_i),
		.op_i        (op_i),
		.last_i      (last),
		.ready_o     (ready_o),
		.mul_load_o  (mul_load),
		.div_load_o  (div_load),
		.cnt_start_o (cnt_start),
		.div_step_o  (div_step),
		.div_fix_o   (div_fix),
		.res_sel_o   (res_sel),
		.done_o      (done_o)
	);

	div_step_counter u_cnt (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.cnt_start_i (cnt_start),
		.step_i      (div_step),
		.word_i      (word_i),
		.last_o      (last)
	);

	div_datapath u_div (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.load_i   (div_load),
		.step_i   (div_step),
		.fix_i    (div_fix),
		.op_i     (op_i),
		.word_i   (word_i),
		.rs1_i    (rs1_i),
		.rs2_i    (rs2_i),
		.result_o (div_res)
	);

	mul_datapath u_mul (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.load_i   (mul_load),
		.op_i     (op_i),
		.word_i   (word_i),
		.rs1_i    (rs1_i),
		.rs2_i    (rs2_i),
		.result_o (mul_res)
	);

	// select flips in the done cycle, so the last result stays put
	assign result_o = res_sel ? div_res : mul_res;

endmodule

// ==== tests/tb_mdu.sv ====
`timescale 1ns/10ps

module tb_mdu;
	import mdu_pkg::*;

	localparam int N_RAND      = 260;
	localparam int N_OPS       = 16 + N_RAND;
	// worst case per op is 66 cycles of divide plus done cycle and idle gap
	localparam int CYCLE_LIMIT = N_OPS * 70 + 16 + 200;

	logic     clk = 1'b0;
	logic     rst_n_i;
	logic     valid_i;
	mdu_op_e  op_i;
	logic     word_i;
	xlen_t    rs1_i;
	xlen_t    rs2_i;
	logic     ready_o;
	logic     done_o;
	xlen_t    result_o;

	logic [31:0] rng_state = 32'h9d77;
	logic        pending   = 1'b0;
	logic        after_rst = 1'b0;
	int          age       = 0;
	int          exp_lat   = 0;
	xlen_t       exp_res   = '0;
	int          n_sent    = 0;
	int          n_acc     = 0;
	int          n_done    = 0;
	int          val_errs  = 0;
	int          proto_errs = 0;
	int          cycles    = 0;

	mdu_top u_mdu_top (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.valid_i  (valid_i),
		.op_i     (op_i),
		.word_i   (word_i),
		.rs1_i    (rs1_i),
		.rs2_i    (rs2_i),
		.ready_o  (ready_o),
		.done_o   (done_o),
		.result_o (result_o)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// corner values mixed in with plain random words
	function automatic xlen_t pick_operand();
		logic [31:0] r;
		r = next_rand();
		case (r[3:0])
			4'd0: return 64'd0;
			4'd1: return '1;
			4'd2: return 64'h8000_0000_0000_0000;
			4'd3: return {next_rand(), 32'h8000_0000};
			4'd4: return {next_rand(), 32'h7fff_ffff};
			4'd5: return {next_rand(), 32'hffff_ffff};
			4'd6: return 64'd1;
			default: return {next_rand(), next_rand()};
		endcase
	endfunction

	function automatic xlen_t divide_rules(input mdu_op_e op, input xlen_t x, input xlen_t y);
		logic rem;
		logic sgn;
		rem = (op == OP_REM) || (op == OP_REMU);
		sgn = (op == OP_DIV) || (op == OP_REM);
		if (y == 64'd0) return rem ? x : '1;
		if (sgn && (x == 64'h8000_0000_0000_0000) && (y == '1)) return rem ? 64'd0 : x;
		if (sgn) return rem ? $signed(x) % $signed(y) : $signed(x) / $signed(y);
		return rem ? x % y : x / y;
	endfunction

	function automatic xlen_t expected_result(input mdu_op_e op, input logic word,
			input xlen_t a, input xlen_t b);
		logic [127:0] prod;
		logic         sgn;
		xlen_t        x;
		xlen_t        y;
		xlen_t        r;
		case (op)
			OP_MULH:   prod = {{64{a[63]}}, a} * {{64{b[63]}}, b};
			OP_MULHSU: prod = {{64{a[63]}}, a} * {64'd0, b};
			default:   prod = {64'd0, a} * {64'd0, b};
		endcase
		if (op == OP_MUL) begin
			r = word ? {{32{prod[31]}}, prod[31:0]} : prod[63:0];
		end else if ((op == OP_MULH) || (op == OP_MULHSU) || (op == OP_MULHU)) begin
			r = prod[127:64];
		end else begin
			// word forms widen the low halves and keep 32 bits of the result
			sgn = (op == OP_DIV) || (op == OP_REM);
			x = word ? {{32{sgn & a[31]}}, a[31:0]} : a;
			y = word ? {{32{sgn & b[31]}}, b[31:0]} : b;
			r = divide_rules(op, x, y);
			if (word) r = {{32{r[31]}}, r[31:0]};
		end
		return r;
	endfunction

	function automatic int expected_latency(input mdu_op_e op, input logic word);
		if ((op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU)) begin
			return word ? 34 : 66;
		end
		return 1;
	endfunction

	// called on a falling edge and returns on the one after acceptance
	task automatic send(input mdu_op_e op, input logic word, input xlen_t a, input xlen_t b);
		valid_i = 1'b1;
		op_i    = op;
		word_i  = word;
		rs1_i   = a;
		rs2_i   = b;
		while (!ready_o) @(negedge clk);
		@(negedge clk);
		valid_i = 1'b0;
		// scramble the idle inputs since the unit must not look at them again
		op_i    = mdu_op_e'(~op);
		word_i  = ~word;
		rs1_i   = ~a;
		rs2_i   = ~b;
		n_sent++;
	endtask

	task automatic wait_done();
		while (!done_o) @(negedge clk);
	endtask

	// scoreboard of the one outstanding request
	always @(posedge clk) begin
		after_rst <= !rst_n_i;
		if (!rst_n_i) begin
			pending <= 1'b0;
			age     <= 0;
		end else begin
			if (done_o) begin
				pending <= 1'b0;
				n_done  <= n_done + 1;
			end
			if (pending) age <= age + 1;
			if (valid_i && ready_o) begin
				pending <= 1'b1;
				age     <= 0;
				exp_res <= expected_result(op_i, word_i, rs1_i, rs2_i);
				exp_lat <= expected_latency(op_i, word_i);
				n_acc   <= n_acc + 1;
			end
		end
	end

	reset_ready: assert property (@(posedge clk) after_rst |-> ready_o)
	else begin
		val_errs++;
		$display("error t=%0t ready_o expected 1 got %b", $time, $sampled(ready_o));
	end

	reset_done: assert property (@(posedge clk) after_rst |-> !done_o)
	else begin
		val_errs++;
		$display("error t=%0t done_o expected 0 got %b", $time, $sampled(done_o));
	end

	busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
		(pending && !done_o) |-> !ready_o)
	else begin
		proto_errs++;
		$display("ready_o was high while an operation was still running, t=%0t", $time);
	end

	done_timing: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o |-> (pending && (age == exp_lat)))
	else begin
		proto_errs++;
		$display("done_o came %0d cycles after acceptance instead of %0d (pending %b), t=%0t",
			$sampled(age), $sampled(exp_lat), $sampled(pending), $time);
	end

	done_missing: assert property (@(posedge clk) disable iff (!rst_n_i)
		pending |-> (age <= exp_lat))
	else begin
		proto_errs++;
		$display("no done_o within %0d cycles of acceptance, t=%0t", $sampled(exp_lat), $time);
	end

	result_value: assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o |-> (result_o == exp_res))
	else begin
		val_errs++;
		$display("error t=%0t result_o expected %h got %h", $time,
			$sampled(exp_res), $sampled(result_o));
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing all operations", cycles);
			$display("errors: %0d value, %0d protocol", val_errs, proto_errs);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int          i;
		int          k;
		int          w;
		int          d;
		logic [31:0] r;
		mdu_op_e     op;

		rst_n_i = 1'b0;
		valid_i = 1'b0;
		op_i    = OP_MUL;
		word_i  = 1'b0;
		rs1_i   = '0;
		rs2_i   = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);

		// divide by zero and overflow with junk in the upper halves of word operands
		for (w = 0; w < 2; w++) begin
			for (d = 4; d < 8; d++) begin
				op = mdu_op_e'(3'(d));
				send(op, w[0], pick_operand(), w ? 64'h0000_abcd_0000_0000 : 64'd0);
				wait_done();
				send(op, w[0], w ? 64'h1234_5678_8000_0000 : 64'h8000_0000_0000_0000, '1);
				wait_done();
			end
		end

		// all 13 ops in turn with some held while busy and some back to back
		for (i = 0; i < N_RAND; i++) begin
			k  = i % 13;
			op = (k < 8) ? mdu_op_e'(3'(k)) : ((k == 8) ? OP_MUL : mdu_op_e'(3'(k - 5)));
			send(op, (k >= 8), pick_operand(), pick_operand());
			r = next_rand();
			if (r[0]) begin
				wait_done();
				if (r[1]) repeat (r[3:2]) @(negedge clk);
			end
		end
		// last result may already be in, so wait on the answer count
		while (n_done < n_sent) @(negedge clk);
		@(negedge clk);
		@(negedge clk);

		answer_count: assert ((n_done == n_sent) && (n_acc == n_sent))
		else begin
			proto_errs++;
			$display("%0d requests sent but %0d accepted and %0d answered",
				n_sent, n_acc, n_done);
		end

		$display("errors: %0d value, %0d protocol", val_errs, proto_errs);
		if ((val_errs + proto_errs) == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== mdu.f ====
+incdir+rtl
rtl/mdu_pkg.sv
rtl/mdu_ctrl.sv
rtl/div_step_counter.sv
rtl/div_datapath.sv
rtl/mul_datapath.sv
rtl/mdu_top.sv
tests/tb_mdu.sv

// ==== Bender.yml ====
package:
  name: mdu

export_include_dirs:
  - rtl

sources:
  - rtl/mdu_pkg.sv
  - rtl/mdu_ctrl.sv
  - rtl/div_step_counter.sv
  - rtl/div_datapath.sv
  - rtl/mul_datapath.sv
  - rtl/mdu_top.sv
  - target: test
    files:
      - tests/tb_mdu.sv
